// ==== include/dma_target_settings.svh ====
// Field positions assume a 34-bit flit with a 2-bit type on top; all sizes count 32-bit words
`ifndef DMA_TARGET_SETTINGS_SVH
`define DMA_TARGET_SETTINGS_SVH

// Bus and network widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define FLIT_WIDTH 34

// Flit type and flit content
`define FLIT_TYPE_MSB 33
`define FLIT_TYPE_LSB 32
`define FLIT_CONTENT_MSB 31
`define FLIT_CONTENT_LSB 0

// Header flit fields
`define DEST_MSB 31
`define DEST_LSB 27
`define CLASS_MSB 26
`define CLASS_LSB 24
`define SOURCE_MSB 23
`define SOURCE_LSB 19
`define PACKET_ID_MSB 18
`define PACKET_ID_LSB 15
`define PACKET_TYPE_MSB 14
`define PACKET_TYPE_LSB 13
// Request-last on requests, response-last on responses
`define LAST_BIT 12
// Word count
`define SIZE_MSB 11
`define SIZE_LSB 0

// Max flits per network packet
`define NOC_PACKET_SIZE 16
// Header and address flit take two slots
`define MAX_PAYLOAD (`NOC_PACKET_SIZE - 2)

// This tile and its traffic class
`define TILE_ID 5'd3
`define CLASS_DMA 3'd6

`endif

// ==== logic/dma_target_pkg.sv ====
// Types follow the flit layout of the settings header; enum encodings are fixed by the NoC protocol
`default_nettype none

`include "dma_target_settings.svh"

package dma_target_pkg;

  // Data types
  typedef logic [`FLIT_WIDTH-1:0] flit_t;
  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DATA_WIDTH-1:0] word_t;
  typedef logic [`DEST_MSB-`DEST_LSB:0] tile_t;
  typedef logic [`PACKET_ID_MSB-`PACKET_ID_LSB:0] pkt_id_t;
  // Word count, same width as the size field
  typedef logic [`SIZE_MSB-`SIZE_LSB:0] wsize_t;

  // Flit type, top two bits of every flit
  typedef enum logic [1:0] {
    PAYLOAD = 2'd0,
    HEADER  = 2'd1,
    LAST    = 2'd2,
    SINGLE  = 2'd3
  } flit_type_e;

  // DMA packet type in the header
  typedef enum logic [1:0] {
    L2R_REQ  = 2'd0,
    R2L_REQ  = 2'd1,
    L2R_RESP = 2'd2,
    R2L_RESP = 2'd3
  } packet_type_e;

  // Control FSM states
  typedef enum logic [3:0] {
    IDLE,
    // Write path
    L2R_GETADDR,
    L2R_DATA,
    L2R_SENDRESP,
    // Read path
    R2L_GETLADDR,
    R2L_GETRADDR,
    R2L_GENHDR,
    R2L_GENADDR,
    R2L_DATA
  } state_e;

endpackage

`default_nettype wire

// ==== logic/dma_req_if.sv ====
// Strobes are single-cycle pulses; captured fields update one clock after the strobe
`timescale 1ns/1ps
`default_nettype none

interface dma_req_if
  import dma_target_pkg::*;
();

  // Capture strobes from the FSM
  logic    cap_header;
  logic    cap_laddr;
  logic    cap_raddr;
  logic    addr_step;

  // Fields of the current request
  logic    end_of_request;
  tile_t   src_tile;
  pkt_id_t packet_id;
  wsize_t  resp_wsize;
  addr_t   local_addr;
  addr_t   remote_addr;

  modport regs (
    input  cap_header, cap_laddr, cap_raddr, addr_step,
    output end_of_request, src_tile, packet_id, resp_wsize, local_addr, remote_addr
  );

  modport ctrl (
    output cap_header, cap_laddr, cap_raddr, addr_step,
    input  end_of_request, src_tile, packet_id, resp_wsize, local_addr, remote_addr
  );

endinterface

`default_nettype wire

// ==== logic/dma_request_regs.sv ====
// Captures from in_flit on FSM strobes only; local address steps by 4, so word-aligned access only
`timescale 1ns/1ps
`default_nettype none

`include "dma_target_settings.svh"

module dma_request_regs
  import dma_target_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  flit_t        in_flit,
  dma_req_if.regs      req
);

  // Content part of the flit, used for both address flits
  addr_t flit_addr;

  assign flit_addr = in_flit[`FLIT_CONTENT_MSB:`FLIT_CONTENT_LSB];

  //////////////////////////////////////////////////////////////////////
  // Header fields
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      req.end_of_request <= 1'b0;
      req.src_tile       <= '0;
      req.packet_id      <= '0;
      req.resp_wsize     <= '0;
    end else if (req.cap_header) begin
      // Ack only when the sender flagged the last request packet
      req.end_of_request <= in_flit[`LAST_BIT];
      // Response goes back to the sender
      req.src_tile       <= in_flit[`SOURCE_MSB:`SOURCE_LSB];
      req.packet_id      <= in_flit[`PACKET_ID_MSB:`PACKET_ID_LSB];
      // Word count of the request
      req.resp_wsize     <= in_flit[`SIZE_MSB:`SIZE_LSB];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Addresses
  //////////////////////////////////////////////////////////////////////

  // Local address, loaded from the flit then stepped per bus transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      req.local_addr <= '0;
    end else if (req.cap_laddr) begin
      req.local_addr <= flit_addr;
    end else if (req.addr_step) begin
      // One word per completed transfer
      req.local_addr <= req.local_addr + addr_t'(4);
    end
  end

  // Remote address, base of the response address flits
  always_ff @(posedge clk) begin
    if (rst) begin
      req.remote_addr <= '0;
    end else if (req.cap_raddr) begin
      req.remote_addr <= flit_addr;
    end
  end

endmodule

`default_nettype wire

// ==== logic/dma_read_fifo.sv ====
// Three entries only; push while full is dropped and pop while empty is ignored
`timescale 1ns/1ps
`default_nettype none

module dma_read_fifo
  import dma_target_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  push,
  input  word_t push_data,
  input  logic  pop,
  output word_t pop_data,
  output logic  empty,
  output logic  full
);

  // Entry 0 is the oldest word
  word_t      mem [3];
  // One-hot write position, bit 0 empty, bit 3 full
  logic [3:0] pos;
  logic       push_ok;
  logic       pop_ok;

  assign empty    = pos[0];
  assign full     = pos[3];
  assign pop_data = mem[0];

  assign push_ok = push & ~full;
  assign pop_ok  = pop & ~empty;

  // Write position moves only on a lone push or a lone pop
  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= 4'b0001;
    end else if (push_ok && !pop_ok) begin
      pos <= pos << 1;
    end else if (pop_ok && !push_ok) begin
      pos <= pos >> 1;
    end
  end

  // Storage shifts toward entry 0 on pop
  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (pop_ok) begin
        if (push_ok && pos[i+1]) begin
          // New word lands one slot below the old write position
          mem[i] <= push_data;
        end else if (i < 2) begin
          mem[i] <= mem[i+1];
        end
      end else if (push_ok && pos[i]) begin
        mem[i] <= push_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/dma_target_fsm.sv ====
// Single-phase bus strobe with read data taken in the hsel & hready cycle; request size must be nonzero
`timescale 1ns/1ps
`default_nettype none

`include "dma_target_settings.svh"

module dma_target_fsm
  import dma_target_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flit_t   in_flit,
  input  logic    in_valid,
  output logic    in_ready,
  output flit_t   out_flit,
  output logic    out_valid,
  input  logic    out_ready,
  output logic    hsel,
  output logic    hwrite,
  input  logic    hready,
  input  word_t   fifo_data,
  input  logic    fifo_empty,
  input  logic    fifo_full,
  output logic    fifo_push,
  output logic    fifo_pop,
  dma_req_if.ctrl req
);

  localparam wsize_t MAX_WORDS = wsize_t'(`MAX_PAYLOAD);

  state_e       state;
  state_e       state_nxt;
  flit_type_e   in_ftype;
  packet_type_e in_ptype;
  logic         in_is_end;
  logic         start_req;
  logic         in_xfer;
  logic         out_xfer;
  logic         bus_xfer;
  logic         r2l_active;
  // Words of the response already closed in earlier packets
  wsize_t       resp_wcount;
  // Words sent in the current packet, and its size
  wsize_t       pkt_wcount;
  wsize_t       pkt_wsize;
  // Words read from the bus so far
  wsize_t       bus_rcount;
  wsize_t       words_left;
  logic         hdr_last;
  wsize_t       hdr_size;
  logic         pkt_end;

  // Input flit decode
  assign in_ftype  = flit_type_e'(in_flit[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB]);
  assign in_ptype  = packet_type_e'(in_flit[`PACKET_TYPE_MSB:`PACKET_TYPE_LSB]);
  assign in_is_end = (in_ftype == LAST) || (in_ftype == SINGLE);
  assign start_req = (in_ftype == HEADER) && ((in_ptype == L2R_REQ) || (in_ptype == R2L_REQ));

  assign in_xfer  = in_valid & in_ready;
  assign out_xfer = out_valid & out_ready;

  // Packet segmentation
  assign words_left = req.resp_wsize - resp_wcount;
  assign hdr_last   = (words_left <= MAX_WORDS);
  assign hdr_size   = hdr_last ? words_left : MAX_WORDS;
  assign pkt_end    = ((pkt_wcount + wsize_t'(1)) == pkt_wsize);

  //////////////////////////////////////////////////////////////////////
  // Bus strobe and FIFO
  //////////////////////////////////////////////////////////////////////

  // Reads overlap header, address and data flits of the response
  assign r2l_active = (state == R2L_GENHDR) || (state == R2L_GENADDR) || (state == R2L_DATA);

  always_comb begin
    hsel = 1'b0;
    if (state == L2R_DATA) begin
      // Write as soon as a data flit is there
      hsel = in_valid;
    end else if (r2l_active) begin
      // Stop at the request size, pause while FIFO is full
      hsel = (bus_rcount != req.resp_wsize) && !fifo_full;
    end
  end

  assign hwrite   = (state == L2R_DATA);
  assign bus_xfer = hsel & hready;
  assign fifo_push = bus_xfer & ~hwrite;
  assign fifo_pop  = (state == R2L_DATA) & out_xfer;

  // Register block strobes
  assign req.cap_header = (state == IDLE) & in_xfer & start_req;
  assign req.cap_laddr  = ((state == L2R_GETADDR) || (state == R2L_GETLADDR)) & in_xfer;
  assign req.cap_raddr  = (state == R2L_GETRADDR) & in_xfer;
  assign req.addr_step  = bus_xfer;

  //////////////////////////////////////////////////////////////////////
  // Network side
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    in_ready = 1'b0;
    case (state)
      IDLE, L2R_GETADDR, R2L_GETLADDR, R2L_GETRADDR: in_ready = 1'b1;
      // Input stalls together with the bus
      L2R_DATA: in_ready = hready;
      default: in_ready = 1'b0;
    endcase
  end

  always_comb begin
    out_valid = 1'b0;
    out_flit  = '0;
    case (state)
      L2R_SENDRESP: begin
        // One-flit write acknowledge
        out_valid = 1'b1;
        out_flit[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB]     = SINGLE;
        out_flit[`DEST_MSB:`DEST_LSB]               = req.src_tile;
        out_flit[`CLASS_MSB:`CLASS_LSB]             = `CLASS_DMA;
        out_flit[`SOURCE_MSB:`SOURCE_LSB]           = `TILE_ID;
        out_flit[`PACKET_ID_MSB:`PACKET_ID_LSB]     = req.packet_id;
        out_flit[`PACKET_TYPE_MSB:`PACKET_TYPE_LSB] = L2R_RESP;
      end
      R2L_GENHDR: begin
        out_valid = 1'b1;
        out_flit[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB]     = HEADER;
        out_flit[`DEST_MSB:`DEST_LSB]               = req.src_tile;
        out_flit[`CLASS_MSB:`CLASS_LSB]             = `CLASS_DMA;
        out_flit[`SOURCE_MSB:`SOURCE_LSB]           = `TILE_ID;
        out_flit[`PACKET_ID_MSB:`PACKET_ID_LSB]     = req.packet_id;
        out_flit[`PACKET_TYPE_MSB:`PACKET_TYPE_LSB] = R2L_RESP;
        // Last packet of the response when the rest fits
        out_flit[`LAST_BIT]                         = hdr_last;
        out_flit[`SIZE_MSB:`SIZE_LSB]               = hdr_size;
      end
      R2L_GENADDR: begin
        // Remote address of this packet's first word
        out_valid = 1'b1;
        out_flit[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB] = PAYLOAD;
        out_flit[`FLIT_CONTENT_MSB:`FLIT_CONTENT_LSB] =
          req.remote_addr + (addr_t'(resp_wcount) << 2);
      end
      R2L_DATA: begin
        // FIFO head, held until taken
        out_valid = !fifo_empty;
        out_flit[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB] = pkt_end ? LAST : PAYLOAD;
        out_flit[`FLIT_CONTENT_MSB:`FLIT_CONTENT_LSB] = fifo_data;
      end
      default: out_valid = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State transitions
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        // Anything but a request header is dropped flit by flit
        if (in_xfer && start_req) begin
          state_nxt = (in_ptype == L2R_REQ) ? L2R_GETADDR : R2L_GETLADDR;
        end
      end
      L2R_GETADDR: if (in_xfer) state_nxt = L2R_DATA;
      L2R_DATA: begin
        if (in_xfer && in_is_end) begin
          state_nxt = req.end_of_request ? L2R_SENDRESP : IDLE;
        end
      end
      L2R_SENDRESP: if (out_xfer) state_nxt = IDLE;
      R2L_GETLADDR: if (in_xfer) state_nxt = R2L_GETRADDR;
      R2L_GETRADDR: if (in_xfer) state_nxt = R2L_GENHDR;
      R2L_GENHDR: if (out_xfer) state_nxt = R2L_GENADDR;
      R2L_GENADDR: if (out_xfer) state_nxt = R2L_DATA;
      R2L_DATA: begin
        if (out_xfer && pkt_end) begin
          // Next packet unless the whole response is out
          state_nxt = (resp_wcount + pkt_wsize == req.resp_wsize) ? IDLE : R2L_GENHDR;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Word counters
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_wcount <= '0;
      pkt_wcount  <= '0;
      pkt_wsize   <= '0;
      bus_rcount  <= '0;
    end else begin
      if (req.cap_header) begin
        resp_wcount <= '0;
        bus_rcount  <= '0;
      end
      if (fifo_push) begin
        bus_rcount <= bus_rcount + wsize_t'(1);
      end
      // Packet size fixed when its header leaves
      if ((state == R2L_GENHDR) && out_xfer) begin
        pkt_wsize  <= hdr_size;
        pkt_wcount <= '0;
      end
      if (fifo_pop) begin
        pkt_wcount <= pkt_wcount + wsize_t'(1);
        if (pkt_end) begin
          resp_wcount <= resp_wcount + pkt_wsize;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/dma_target_top.sv ====
// Single-phase bus: haddr and hwdata are valid in the cycle hsel and hready are both high
`timescale 1ns/1ps
`default_nettype none

`include "dma_target_settings.svh"

module dma_target_top
  import dma_target_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  // Network input
  input  flit_t noc_in_flit,
  input  logic  noc_in_valid,
  output logic  noc_in_ready,
  // Network output
  output flit_t noc_out_flit,
  output logic  noc_out_valid,
  input  logic  noc_out_ready,
  // Bus master
  output logic  hsel,
  output addr_t haddr,
  output logic  hwrite,
  output word_t hwdata,
  input  word_t hrdata,
  input  logic  hready
);

  // Read data FIFO
  logic  fifo_push;
  logic  fifo_pop;
  word_t fifo_data;
  logic  fifo_empty;
  logic  fifo_full;

  // Request fields between register block and FSM
  dma_req_if req_if ();

  // Bus address tracks the stepped local address
  assign haddr  = req_if.local_addr;
  // Write data straight from the data flit
  assign hwdata = noc_in_flit[`FLIT_CONTENT_MSB:`FLIT_CONTENT_LSB];

  dma_request_regs u_regs (
    .clk     (clk),
    .rst     (rst),
    .in_flit (noc_in_flit),
    .req     (req_if.regs)
  );

  dma_target_fsm u_fsm (
    .clk        (clk),
    .rst        (rst),
    .in_flit    (noc_in_flit),
    .in_valid   (noc_in_valid),
    .in_ready   (noc_in_ready),
    .out_flit   (noc_out_flit),
    .out_valid  (noc_out_valid),
    .out_ready  (noc_out_ready),
    .hsel       (hsel),
    .hwrite     (hwrite),
    .hready     (hready),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .fifo_push  (fifo_push),
    .fifo_pop   (fifo_pop),
    .req        (req_if.ctrl)
  );

  dma_read_fifo u_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (fifo_push),
    .push_data (hrdata),
    .pop       (fifo_pop),
    .pop_data  (fifo_data),
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

endmodule

`default_nettype wire

// ==== testbench/ahb_mem_model.sv ====
// Holds 256 words (1 KiB); haddr bits above 9 wrap, and only whole aligned words are stored
`timescale 1ns/1ps
`default_nettype none

module ahb_mem_model
  import dma_target_pkg::*;
(
  input  logic  clk,
  // Stall request from the testbench random source
  input  logic  stall,
  input  logic  hsel,
  input  addr_t haddr,
  input  logic  hwrite,
  input  word_t hwdata,
  output word_t hrdata,
  output logic  hready
);

  localparam int DEPTH = 256;

  word_t      mem [DEPTH];
  logic [7:0] idx;

  // Word index from the byte address
  assign idx    = haddr[9:2];
  assign hready = ~stall;
  // Read data valid in the strobe cycle itself
  assign hrdata = mem[idx];

  // Fill pattern depends on every bit of the index
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 32'h5eed_0000 ^ (i * 32'h9e37_79b1);
    end
  end

  // Write lands at the edge that ends the strobe cycle
  always @(posedge clk) begin
    if (hsel && hready && hwrite) begin
      mem[idx] <= hwdata;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/dma_target_tb.sv ====
// Table addresses must stay below 0x400; reference memory is taken from the model after reset
`timescale 1ns/1ps
`default_nettype none

`include "dma_target_settings.svh"

module dma_target_tb
  import dma_target_pkg::*;
();

  localparam int          ROWS         = 7;
  localparam int          TIMEOUT      = 2000;
  localparam int          QUIET_CYCLES = 24;
  localparam logic [31:0] SEED         = 32'h93a6;

  // One request per row
  typedef struct packed {
    packet_type_e kind;
    tile_t        src;
    pkt_id_t      id;
    wsize_t       size;
    logic         last;
    addr_t        laddr;
    addr_t        raddr;
  } row_t;

  logic        clk;
  logic        rst;
  flit_t       noc_in_flit;
  logic        noc_in_valid;
  logic        noc_in_ready;
  flit_t       noc_out_flit;
  logic        noc_out_valid;
  logic        noc_out_ready;
  logic        hsel;
  addr_t       haddr;
  logic        hwrite;
  word_t       hwdata;
  word_t       hrdata;
  logic        hready;
  logic        stall;
  logic [31:0] lfsr;
  flit_t       out_q [$];
  int          bus_cnt = 0;
  word_t       shadow [256];
  row_t        rows [ROWS];

  dma_target_top dut (
    .clk           (clk),
    .rst           (rst),
    .noc_in_flit   (noc_in_flit),
    .noc_in_valid  (noc_in_valid),
    .noc_in_ready  (noc_in_ready),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .hsel          (hsel),
    .haddr         (haddr),
    .hwrite        (hwrite),
    .hwdata        (hwdata),
    .hrdata        (hrdata),
    .hready        (hready)
  );

  ahb_mem_model u_mem (
    .clk    (clk),
    .stall  (stall),
    .hsel   (hsel),
    .haddr  (haddr),
    .hwrite (hwrite),
    .hwdata (hwdata),
    .hrdata (hrdata),
    .hready (hready)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Random back-pressure and bus stalls
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bit(output logic b);
    b = lfsr[0];
    lfsr = lfsr_next(lfsr);
  endtask

  always @(negedge clk) begin
    logic r0;
    logic r1;
    logic r2;
    draw_bit(r0);
    draw_bit(r1);
    draw_bit(r2);
    noc_out_ready = r0;
    // Stall about one cycle in four
    stall = r1 & r2;
  end

  // Output flits and bus transfers as seen at the clock edge
  always @(posedge clk) begin
    if (!rst && noc_out_valid && noc_out_ready) begin
      out_q.push_back(noc_out_flit);
    end
    if (!rst && hsel && hready) begin
      bus_cnt <= bus_cnt + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks and flit helpers
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_flit(input string name, input flit_t exp, input flit_t act);
    if (act !== exp) fail_run($sformatf("error %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) fail_run($sformatf("error %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) fail_run($sformatf("error %s expected %h actual %h", name, exp, act));
  endtask

  function automatic flit_t make_header(input flit_type_e ft, input tile_t dest,
                                        input tile_t src, input pkt_id_t id,
                                        input packet_type_e pt, input logic last,
                                        input wsize_t size);
    flit_t f;
    f = '0;
    f[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB]     = ft;
    f[`DEST_MSB:`DEST_LSB]               = dest;
    f[`CLASS_MSB:`CLASS_LSB]             = `CLASS_DMA;
    f[`SOURCE_MSB:`SOURCE_LSB]           = src;
    f[`PACKET_ID_MSB:`PACKET_ID_LSB]     = id;
    f[`PACKET_TYPE_MSB:`PACKET_TYPE_LSB] = pt;
    f[`LAST_BIT]                         = last;
    f[`SIZE_MSB:`SIZE_LSB]               = size;
    return f;
  endfunction

  // Address or data flit, typed LAST when it closes the packet
  function automatic flit_t make_data(input logic is_last, input word_t w);
    flit_t f;
    f = '0;
    if (is_last) f[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB] = LAST;
    else f[`FLIT_TYPE_MSB:`FLIT_TYPE_LSB] = PAYLOAD;
    f[`FLIT_CONTENT_MSB:`FLIT_CONTENT_LSB] = w;
    return f;
  endfunction

  function automatic word_t write_word(input int row, input int w);
    return 32'hda7a_0000 ^ word_t'(row << 12) ^ word_t'(w);
  endfunction

  // Held on the input until the DUT takes it
  task automatic send_flit(input flit_t f, input string what);
    int n;
    @(negedge clk);
    noc_in_flit  = f;
    noc_in_valid = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) fail_run({what, " was never accepted by the DUT"});
    end while (!(noc_in_valid && noc_in_ready));
  endtask

  task automatic release_input();
    @(negedge clk);
    noc_in_valid = 1'b0;
  endtask

  task automatic next_out_flit(output flit_t f, input string what);
    int n;
    n = 0;
    while (out_q.size() == 0) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) fail_run({what, " never arrived on the network output"});
    end
    f = out_q.pop_front();
  endtask

  task automatic expect_quiet(input string what);
    for (int n = 0; n < QUIET_CYCLES; n++) begin
      @(negedge clk);
      if (out_q.size() != 0) fail_run({"unexpected output flit after ", what});
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Request runners
  //////////////////////////////////////////////////////////////////////

  task automatic run_write(input int r);
    int    b0;
    int    idx;
    flit_t f;
    b0 = bus_cnt;
    send_flit(make_header(HEADER, `TILE_ID, rows[r].src, rows[r].id, L2R_REQ,
                          rows[r].last, rows[r].size), "write header");
    send_flit(make_data(1'b0, rows[r].laddr), "write address flit");
    for (int w = 0; w < rows[r].size; w++) begin
      idx = ((rows[r].laddr >> 2) + w) % 256;
      send_flit(make_data(w == rows[r].size - 1, write_word(r, w)), "write data flit");
      shadow[idx] = write_word(r, w);
    end
    release_input();
    // Ack only for the last request packet
    if (rows[r].last) begin
      next_out_flit(f, "write acknowledge");
      check_flit("noc_out_flit", make_header(SINGLE, rows[r].src, `TILE_ID, rows[r].id,
                                             L2R_RESP, 1'b0, '0), f);
    end
    expect_quiet("write request");
    if (bus_cnt - b0 != rows[r].size) fail_run("write did not take one bus transfer per word");
    for (int w = 0; w < rows[r].size; w++) begin
      idx = ((rows[r].laddr >> 2) + w) % 256;
      check_word($sformatf("mem[%0d]", idx), shadow[idx], u_mem.mem[idx]);
    end
  endtask

  task automatic run_read(input int r);
    int    b0;
    int    done;
    int    left;
    int    psize;
    int    idx;
    flit_t f;
    b0 = bus_cnt;
    send_flit(make_header(HEADER, `TILE_ID, rows[r].src, rows[r].id, R2L_REQ,
                          rows[r].last, rows[r].size), "read header");
    send_flit(make_data(1'b0, rows[r].laddr), "read local address flit");
    send_flit(make_data(1'b1, rows[r].raddr), "read remote address flit");
    release_input();
    done = 0;
    // One response packet per pass, at most MAX_PAYLOAD words each
    while (done < rows[r].size) begin
      left  = rows[r].size - done;
      psize = (left <= `MAX_PAYLOAD) ? left : `MAX_PAYLOAD;
      next_out_flit(f, "read response header");
      check_flit("noc_out_flit", make_header(HEADER, rows[r].src, `TILE_ID, rows[r].id,
                                             R2L_RESP, left <= `MAX_PAYLOAD,
                                             wsize_t'(psize)), f);
      next_out_flit(f, "read response address flit");
      check_flit("noc_out_flit", make_data(1'b0, rows[r].raddr + addr_t'(4 * done)), f);
      for (int w = 0; w < psize; w++) begin
        idx = ((rows[r].laddr >> 2) + done + w) % 256;
        next_out_flit(f, "read response data flit");
        check_flit("noc_out_flit", make_data(w == psize - 1, shadow[idx]), f);
      end
      done += psize;
    end
    expect_quiet("read response");
    if (bus_cnt - b0 != rows[r].size) fail_run("read did not take one bus transfer per word");
    // Reads leave the memory untouched
    for (int w = 0; w < rows[r].size; w++) begin
      idx = ((rows[r].laddr >> 2) + w) % 256;
      check_word($sformatf("mem[%0d]", idx), shadow[idx], u_mem.mem[idx]);
    end
  endtask

  // Unknown request type, must leave bus and output untouched
  task automatic run_discard(input int r);
    int b0;
    b0 = bus_cnt;
    send_flit(make_header(HEADER, `TILE_ID, rows[r].src, rows[r].id, rows[r].kind,
                          rows[r].last, rows[r].size), "discarded header");
    release_input();
    expect_quiet("discarded header");
    if (bus_cnt != b0) fail_run("bus transfer seen for a discarded packet");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    lfsr          = SEED;
    rst           = 1'b1;
    noc_in_flit   = '0;
    noc_in_valid  = 1'b0;
    noc_out_ready = 1'b0;
    stall         = 1'b0;
    // kind, src, id, size, last, local address, remote address
    rows[0] = '{L2R_REQ,  5'd1,  4'd2,  12'd5,  1'b1, 32'h0000_0040, 32'h0};
    // Split write, ack only after the second part
    rows[1] = '{L2R_REQ,  5'd7,  4'd5,  12'd3,  1'b0, 32'h0000_0100, 32'h0};
    rows[2] = '{L2R_REQ,  5'd7,  4'd5,  12'd4,  1'b1, 32'h0000_010c, 32'h0};
    rows[3] = '{R2L_REQ,  5'd9,  4'd3,  12'd6,  1'b1, 32'h0000_0040, 32'h8000_1000};
    // Three packets of 14, 14 and 2 words
    rows[4] = '{R2L_REQ,  5'd12, 4'd9,  12'd30, 1'b1, 32'h0000_0200, 32'h2000_0400};
    rows[5] = '{L2R_RESP, 5'd4,  4'd1,  12'd2,  1'b0, 32'h0,         32'h0};
    rows[6] = '{R2L_REQ,  5'd2,  4'd14, 12'd2,  1'b1, 32'h0000_0100, 32'h0000_0c00};
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    // Idle outputs right after reset
    check_bit("noc_out_valid", 1'b0, noc_out_valid);
    check_bit("hsel", 1'b0, hsel);
    check_bit("noc_in_ready", 1'b1, noc_in_ready);
    for (int i = 0; i < 256; i++) begin
      shadow[i] = u_mem.mem[i];
    end
    for (int r = 0; r < ROWS; r++) begin
      case (rows[r].kind)
        L2R_REQ: run_write(r);
        R2L_REQ: run_read(r);
        default: run_discard(r);
      endcase
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
logic/dma_target_pkg.sv
logic/dma_req_if.sv
logic/dma_request_regs.sv
logic/dma_read_fifo.sv
logic/dma_target_fsm.sv
logic/dma_target_top.sv
testbench/ahb_mem_model.sv
testbench/dma_target_tb.sv

// ==== Bender.yml ====
package:
  name: dma_target

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/dma_target_pkg.sv
      - logic/dma_req_if.sv
      - logic/dma_request_regs.sv
      - logic/dma_read_fifo.sv
      - logic/dma_target_fsm.sv
      - logic/dma_target_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/ahb_mem_model.sv
      - testbench/dma_target_tb.sv
